//--- logic/dcache.sv
`timescale 1ns/1ps

module dcache import rv32i_types::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      read,
   input  logic      write,
   input  logic [3:0] wmask,
   input  mem_addr_u addr,
   input  rv32i_word wdata,
   output logic      resp,
   output rv32i_word rdata,
   output line_req_t line_req,
   input  line_rsp_t line_rsp,
   output logic      hit,
   output logic      miss
);

   addr_line_t a;
   logic [cache_offset_bits-3:0] word;
   logic [cache_lines-1:0] valid;
   logic [cache_lines-1:0] dirty;
   logic [cache_tag_bits-1:0] tags [cache_lines];
   cache_line lines [cache_lines];
   logic wb_state;
   logic fill_state;
   logic req;
   logic lookup_hit;
   cache_line fill_line;

   // byte-masked merge of one store word into a line
   function automatic cache_line merge_word(cache_line l, logic [2:0] w, rv32i_word d,
                                            logic [3:0] m);
      cache_line r;
      r = l;
      for (int b = 0; b < 4; b++) begin
         if (m[b]) begin
            r[w*32 + b*8 +: 8] = d[b*8 +: 8];
         end
      end
      return r;
   endfunction

   assign a = addr.line;
   assign word = a.offset[cache_offset_bits-1:2];

   assign req = (read || write) && !resp && !wb_state && !fill_state;
   assign lookup_hit = valid[a.index] && (tags[a.index] == a.tag);
   assign hit = req && lookup_hit;
   assign miss = req && !lookup_hit;

   // write-allocate: the store lands in the freshly filled line
   assign fill_line = write ? merge_word(line_rsp.rdata, word, wdata, wmask) : line_rsp.rdata;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid <= '0;
         dirty <= '0;
         wb_state <= 1'b0;
         fill_state <= 1'b0;
         resp <= 1'b0;
      end else begin
         resp <= 1'b0;
         if (hit) begin
            resp <= 1'b1;
            if (write) begin
               dirty[a.index] <= 1'b1;
            end
         end else if (miss) begin
            // dirty victim goes out before the fill
            if (valid[a.index] && dirty[a.index]) begin
               wb_state <= 1'b1;
            end else begin
               fill_state <= 1'b1;
            end
         end else if (wb_state && line_rsp.resp) begin
            wb_state <= 1'b0;
            fill_state <= 1'b1;
            dirty[a.index] <= 1'b0;
         end else if (fill_state && line_rsp.resp) begin
            fill_state <= 1'b0;
            valid[a.index] <= 1'b1;
            dirty[a.index] <= write;
            resp <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (hit && write) begin
         lines[a.index] <= merge_word(lines[a.index], word, wdata, wmask);
      end
      if (hit && read) begin
         rdata <= lines[a.index][word*32 +: 32];
      end
      if (fill_state && line_rsp.resp) begin
         lines[a.index] <= fill_line;
         tags[a.index] <= a.tag;
         rdata <= fill_line[word*32 +: 32];
      end
   end

   always_comb begin
      line_req.read = fill_state;
      line_req.write = wb_state;
      line_req.wdata = lines[a.index];
      if (wb_state) begin
         line_req.addr = {tags[a.index], a.index, {cache_offset_bits{1'b0}}};
      end else begin
         line_req.addr = {a.tag, a.index, {cache_offset_bits{1'b0}}};
      end
   end

   a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n) !(read && write));

endmodule : dcache

//--- logic/external_write_buffer.sv
`timescale 1ns/1ps

module external_write_buffer import rv32i_types::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  line_req_t req,
   output line_rsp_t rsp,
   output logic      rd_read,
   output rv32i_word rd_addr,
   input  line_rsp_t rd_rsp,
   output logic      drain_write,
   output rv32i_word drain_addr,
   output cache_line drain_data,
   input  logic      drain_done,
   output logic      drain
);

   logic full;
   logic rsp_q;
   logic match;
   logic take_write;
   logic take_fwd;
   rv32i_word buf_addr;
   cache_line buf_data;
   cache_line fwd_data;

   // line address compare only
   assign match = full &&
      (req.addr[31:cache_offset_bits] == buf_addr[31:cache_offset_bits]);

   // full buffer holds off the next eviction until drained
   assign take_write = req.write && !full && !rsp_q;
   assign take_fwd = req.read && match && !rsp_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         full <= 1'b0;
         rsp_q <= 1'b0;
      end else begin
         rsp_q <= take_write || take_fwd;
         if (take_write) begin
            full <= 1'b1;
         end else if (drain_done) begin
            full <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take_write) begin
         buf_addr <= req.addr;
         buf_data <= req.wdata;
      end
      if (take_fwd) begin
         fwd_data <= buf_data;
      end
   end

   // misses in the buffer go on to pmem
   assign rd_read = req.read && !match && !rsp_q;
   assign rd_addr = req.addr;

   assign rsp.resp = rsp_q || rd_rsp.resp;
   assign rsp.rdata = rsp_q ? fwd_data : rd_rsp.rdata;

   assign drain_write = full;
   assign drain_addr = buf_addr;
   assign drain_data = buf_data;
   assign drain = drain_done;

endmodule : external_write_buffer

//--- logic/icache.sv
`timescale 1ns/1ps

module icache import rv32i_types::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      read,
   input  rv32i_word addr,
   output logic      resp,
   output rv32i_word rdata,
   output line_req_t line_req,
   input  line_rsp_t line_rsp,
   output logic      hit,
   output logic      miss
);

   addr_line_t a;
   logic [cache_offset_bits-3:0] word;
   logic [cache_lines-1:0] valid;
   logic [cache_tag_bits-1:0] tags [cache_lines];
   cache_line lines [cache_lines];
   logic filling;
   logic req;
   logic lookup_hit;

   assign a = addr;
   assign word = a.offset[cache_offset_bits-1:2];

   // a held request is ignored in its own resp cycle
   assign req = read && !resp && !filling;
   assign lookup_hit = valid[a.index] && (tags[a.index] == a.tag);
   assign hit = req && lookup_hit;
   assign miss = req && !lookup_hit;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid <= '0;
         filling <= 1'b0;
         resp <= 1'b0;
      end else begin
         resp <= 1'b0;
         if (hit) begin
            resp <= 1'b1;
         end else if (miss) begin
            filling <= 1'b1;
         end else if (filling && line_rsp.resp) begin
            filling <= 1'b0;
            valid[a.index] <= 1'b1;
            resp <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (hit) begin
         rdata <= lines[a.index][word*32 +: 32];
      end
      // answer straight from the refill data
      if (filling && line_rsp.resp) begin
         lines[a.index] <= line_rsp.rdata;
         tags[a.index] <= a.tag;
         rdata <= line_rsp.rdata[word*32 +: 32];
      end
   end

   always_comb begin
      line_req.read = filling;
      line_req.write = 1'b0;
      line_req.addr = {a.tag, a.index, {cache_offset_bits{1'b0}}};
      line_req.wdata = '0;
   end

   // refill data only comes back for an outstanding refill
   a_rsp_when_filling: assert property (@(posedge clk) disable iff (!rst_n)
      line_rsp.resp |-> filling);

endmodule : icache

//--- logic/l1_arbiter.sv
`timescale 1ns/1ps

module l1_arbiter import rv32i_types::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  line_req_t i_req,
   output line_rsp_t i_rsp,
   input  line_req_t d_req,
   output line_rsp_t d_rsp,
   output line_req_t mem_req,
   input  line_rsp_t mem_rsp
);

   logic busy;
   logic grant_d;

   // grant is held until the granted transaction completes
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy <= 1'b0;
         grant_d <= 1'b0;
      end else if (!busy) begin
         if (d_req.read || d_req.write) begin
            busy <= 1'b1;
            grant_d <= 1'b1;
         end else if (i_req.read) begin
            busy <= 1'b1;
            grant_d <= 1'b0;
         end
      end else if (mem_rsp.resp) begin
         busy <= 1'b0;
      end
   end

   always_comb begin
      mem_req = '0;
      if (busy) begin
         mem_req = grant_d ? d_req : i_req;
      end
   end

   always_comb begin
      i_rsp.rdata = mem_rsp.rdata;
      d_rsp.rdata = mem_rsp.rdata;
      i_rsp.resp = busy && !grant_d && mem_rsp.resp;
      d_rsp.resp = busy && grant_d && mem_rsp.resp;
   end

   // no response from below without a granted request
   a_rsp_in_grant: assert property (@(posedge clk) disable iff (!rst_n)
      mem_rsp.resp |-> busy);

endmodule : l1_arbiter

//--- logic/mem_heirarchy.sv
`timescale 1ns/1ps

module mem_heirarchy import rv32i_types::*; (
   input  logic       clk,
   input  logic       rst_n,

   // port A, fetch
   input  logic       read_a,
   input  rv32i_word  address_a,
   output logic       resp_a,
   output rv32i_word  rdata_a,

   // port B, load and store
   input  logic       read_b,
   input  logic       write,
   input  logic [3:0] wmask,
   input  rv32i_word  address_b,
   input  rv32i_word  wdata,
   output logic       resp_b,
   output rv32i_word  rdata_b,

   output logic       pmem_read,
   output logic       pmem_write,
   output rv32i_word  pmem_address,
   input  cache_line  pmem_rdata,
   output cache_line  pmem_wdata,
   input  logic       pmem_resp,

   input  rv32i_word  branch_total_count,
   input  rv32i_word  branch_incorrect_count,
   output logic       branch_total_reset,
   output logic       branch_incorrect_reset
);

   line_req_t i_line_req;
   line_req_t d_line_req;
   line_req_t l1_mem_req;
   line_rsp_t i_line_rsp;
   line_rsp_t d_line_rsp;
   line_rsp_t l1_mem_rsp;
   line_rsp_t rd_rsp;
   perf_events_t events;

   logic dcache_read;
   logic dcache_write;
   logic dcache_resp;
   logic counter_resp;
   rv32i_word dcache_rdata;

   logic rd_read;
   rv32i_word rd_addr;
   logic drain_write;
   rv32i_word drain_addr;
   cache_line drain_data;
   logic drain_done;

   assign resp_b = counter_resp | dcache_resp;

   icache icache (
      .clk, .rst_n,
      .read(read_a), .addr(address_a), .resp(resp_a), .rdata(rdata_a),
      .line_req(i_line_req), .line_rsp(i_line_rsp),
      .hit(events.icache_hit), .miss(events.icache_miss)
   );

   dcache dcache (
      .clk, .rst_n,
      .read(dcache_read), .write(dcache_write), .wmask, .addr(address_b), .wdata,
      .resp(dcache_resp), .rdata(dcache_rdata),
      .line_req(d_line_req), .line_rsp(d_line_rsp),
      .hit(events.dcache_hit), .miss(events.dcache_miss)
   );

   perf_counter perf_counter (
      .clk, .rst_n,
      .read(read_b), .write, .addr(address_b),
      .dcache_read, .dcache_write,
      .resp(counter_resp), .rdata(rdata_b), .dcache_rdata,
      .events,
      .branch_total_count, .branch_incorrect_count,
      .branch_total_reset, .branch_incorrect_reset
   );

   l1_arbiter l1_arbiter (
      .clk, .rst_n,
      .i_req(i_line_req), .i_rsp(i_line_rsp),
      .d_req(d_line_req), .d_rsp(d_line_rsp),
      .mem_req(l1_mem_req), .mem_rsp(l1_mem_rsp)
   );

   external_write_buffer ewb (
      .clk, .rst_n,
      .req(l1_mem_req), .rsp(l1_mem_rsp),
      .rd_read, .rd_addr, .rd_rsp,
      .drain_write, .drain_addr, .drain_data, .drain_done,
      .drain(events.ewb_drain)
   );

   pmem_arbiter pmem_arbiter (
      .clk, .rst_n,
      .rd_read, .rd_addr, .rd_rsp,
      .drain_write, .drain_addr, .drain_data, .drain_done,
      .pmem_read, .pmem_write, .pmem_address, .pmem_rdata, .pmem_wdata, .pmem_resp
   );

endmodule : mem_heirarchy

//--- logic/perf_counter.sv
`timescale 1ns/1ps

module perf_counter import rv32i_types::*; (
   input  logic         clk,
   input  logic         rst_n,
   input  logic         read,
   input  logic         write,
   input  mem_addr_u    addr,
   output logic         dcache_read,
   output logic         dcache_write,
   output logic         resp,
   output rv32i_word    rdata,
   input  rv32i_word    dcache_rdata,
   input  perf_events_t events,
   input  rv32i_word    branch_total_count,
   input  rv32i_word    branch_incorrect_count,
   output logic         branch_total_reset,
   output logic         branch_incorrect_reset
);

   logic in_window;
   logic access;
   logic [5:0] sel;
   logic [num_event_counters-1:0] ev_vec;
   rv32i_word counts [num_event_counters];
   rv32i_word sel_value;
   rv32i_word ctr_rdata;

   assign in_window = (addr.mmio.region == mmio_base);
   assign sel = addr.mmio.sel;
   assign access = (read || write) && in_window && !resp;

   // everything outside the window belongs to the dcache
   assign dcache_read = read && !in_window;
   assign dcache_write = write && !in_window;

   assign ev_vec = {events.ewb_drain, events.dcache_miss, events.dcache_hit,
                    events.icache_miss, events.icache_hit};

   always_comb begin
      sel_value = '0;
      if (sel < num_event_counters) begin
         sel_value = counts[sel[2:0]];
      end else if (sel == sel_branch_total) begin
         sel_value = branch_total_count;
      end else if (sel == sel_branch_incorrect) begin
         sel_value = branch_incorrect_count;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         resp <= 1'b0;
         branch_total_reset <= 1'b0;
         branch_incorrect_reset <= 1'b0;
         for (int i = 0; i < num_event_counters; i++) begin
            counts[i] <= '0;
         end
      end else begin
         resp <= access;
         branch_total_reset <= access && write && (sel == sel_branch_total);
         branch_incorrect_reset <= access && write && (sel == sel_branch_incorrect);
         // a software clear wins over an event in the same cycle
         for (int i = 0; i < num_event_counters; i++) begin
            if (access && write && (sel == i)) begin
               counts[i] <= '0;
            end else if (ev_vec[i]) begin
               counts[i] <= counts[i] + 32'd1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (access && read) begin
         ctr_rdata <= sel_value;
      end
   end

   assign rdata = resp ? ctr_rdata : dcache_rdata;

endmodule : perf_counter

//--- logic/pmem_arbiter.sv
`timescale 1ns/1ps

module pmem_arbiter import rv32i_types::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      rd_read,
   input  rv32i_word rd_addr,
   output line_rsp_t rd_rsp,
   input  logic      drain_write,
   input  rv32i_word drain_addr,
   input  cache_line drain_data,
   output logic      drain_done,
   output logic      pmem_read,
   output logic      pmem_write,
   output rv32i_word pmem_address,
   input  cache_line pmem_rdata,
   output cache_line pmem_wdata,
   input  logic      pmem_resp
);

   logic busy;
   logic own_drain;

   // reads go first, but an owner keeps the port until pmem_resp
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy <= 1'b0;
         own_drain <= 1'b0;
      end else if (!busy) begin
         if (rd_read) begin
            busy <= 1'b1;
            own_drain <= 1'b0;
         end else if (drain_write) begin
            busy <= 1'b1;
            own_drain <= 1'b1;
         end
      end else if (pmem_resp) begin
         busy <= 1'b0;
      end
   end

   assign pmem_read = busy && !own_drain;
   assign pmem_write = busy && own_drain;
   assign pmem_address = own_drain ? drain_addr : rd_addr;
   assign pmem_wdata = drain_data;

   assign rd_rsp.resp = pmem_read && pmem_resp;
   assign rd_rsp.rdata = pmem_rdata;
   assign drain_done = pmem_write && pmem_resp;

endmodule : pmem_arbiter

//--- logic/rv32i_types.sv
package rv32i_types;

   typedef logic [31:0] rv32i_word;
   typedef logic [255:0] cache_line;

   // cache geometry
   localparam int line_bytes = 32;
   localparam int cache_offset_bits = $clog2(line_bytes);
   localparam int cache_index_bits = 3;
   localparam int cache_lines = 1 << cache_index_bits;
   localparam int cache_tag_bits = 24;

   // counter window, upper 24 address bits
   localparam logic [23:0] mmio_base = 24'hFFFFFF;
   localparam int num_event_counters = 5;
   localparam int sel_branch_total = 5;
   localparam int sel_branch_incorrect = 6;

   typedef struct packed {
      logic [cache_tag_bits-1:0]    tag;
      logic [cache_index_bits-1:0]  index;
      logic [cache_offset_bits-1:0] offset;
   } addr_line_t;

   typedef struct packed {
      logic [23:0] region;
      logic [5:0]  sel;
      logic [1:0]  byte_sel;
   } addr_mmio_t;

   // port B address, seen by the dcache and by the counter block
   typedef union packed {
      addr_line_t line;
      addr_mmio_t mmio;
   } mem_addr_u;

   typedef struct packed {
      logic      read;
      logic      write;
      rv32i_word addr;
      cache_line wdata;
   } line_req_t;

   typedef struct packed {
      logic      resp;
      cache_line rdata;
   } line_rsp_t;

   typedef struct packed {
      logic icache_hit;
      logic icache_miss;
      logic dcache_hit;
      logic dcache_miss;
      logic ewb_drain;
   } perf_events_t;

endpackage : rv32i_types

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the memory hierarchy testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f src.f \
   --top-module tb_mem_heirarchy \
   --Mdir build \
   -o sim

# the simulator exits non-zero on failure, so keep its output for the search
sim_output=$(./build/sim 2>&1) || true
echo "$sim_output"

if grep -q "Simulation PASSED" <<< "$sim_output"; then
   echo "run_sim: pass"
   exit 0
else
   echo "run_sim: fail"
   exit 1
fi

//--- src.f
logic/rv32i_types.sv
logic/icache.sv
logic/dcache.sv
logic/perf_counter.sv
logic/l1_arbiter.sv
logic/external_write_buffer.sv
logic/pmem_arbiter.sv
logic/mem_heirarchy.sv
verif/pmem_model.sv
verif/tb_mem_heirarchy.sv

//--- verif/pmem_model.sv
`timescale 1ns/1ps

module pmem_model import rv32i_types::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  logic      pmem_read,
   input  logic      pmem_write,
   input  rv32i_word pmem_address,
   output cache_line pmem_rdata,
   input  cache_line pmem_wdata,
   output logic      pmem_resp
);

   localparam int resp_delay = 3;

   // only written lines are stored, the rest follow the fill pattern
   cache_line mem [rv32i_word];
   logic busy;
   logic is_write;
   int count;
   rv32i_word line_addr;

   function automatic cache_line initial_line(rv32i_word base);
      cache_line l;
      for (int w = 0; w < 8; w++) begin
         l[w*32 +: 32] = (base + 32'(w * 4)) ^ 32'hA5A5A5A5;
      end
      return l;
   endfunction

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy <= 1'b0;
         is_write <= 1'b0;
         count <= 0;
         pmem_resp <= 1'b0;
      end else if (pmem_resp) begin
         pmem_resp <= 1'b0;
         busy <= 1'b0;
      end else if (busy) begin
         if (count == 1) begin
            pmem_resp <= 1'b1;
            if (is_write) begin
               mem[line_addr] = pmem_wdata;
            end else if (mem.exists(line_addr)) begin
               pmem_rdata <= mem[line_addr];
            end else begin
               pmem_rdata <= initial_line(line_addr);
            end
         end else begin
            count <= count - 1;
         end
      end else if (pmem_read || pmem_write) begin
         busy <= 1'b1;
         is_write <= pmem_write;
         count <= resp_delay;
         line_addr <= {pmem_address[31:5], 5'b00000};
      end
   end

endmodule : pmem_model

//--- verif/tb_mem_heirarchy.sv
`timescale 1ns/1ps

module tb_mem_heirarchy import rv32i_types::*;;

   localparam int clk_period = 40;
   localparam int drive_delay = 2;
   localparam int reset_cycles = 8;
   localparam int cycles_per_row = 40;
   localparam int random_rows = 24;

   typedef enum logic {port_a, port_b} port_e;
   typedef enum logic [2:0] {op_fetch, op_load, op_store, op_ctr_read, op_ctr_write} op_e;

   typedef struct packed {
      port_e      port;
      op_e        op;
      rv32i_word  addr;
      rv32i_word  wdata;
      logic [3:0] wmask;
      rv32i_word  expected;
      logic       fast;
   } row_t;

   logic       clk;
   logic       rst_n;
   logic       read_a;
   rv32i_word  address_a;
   logic       resp_a;
   rv32i_word  rdata_a;
   logic       read_b;
   logic       write;
   logic [3:0] wmask;
   rv32i_word  address_b;
   rv32i_word  wdata;
   logic       resp_b;
   rv32i_word  rdata_b;
   logic       pmem_read;
   logic       pmem_write;
   rv32i_word  pmem_address;
   cache_line  pmem_rdata;
   cache_line  pmem_wdata;
   logic       pmem_resp;
   rv32i_word  branch_total_count;
   rv32i_word  branch_incorrect_count;
   logic       branch_total_reset;
   logic       branch_incorrect_reset;

   row_t rows[$];
   string names[$];
   logic table_ready;

   // shadow memory by word address, and a tag model of both caches
   rv32i_word shadow [rv32i_word];
   logic [cache_lines-1:0] i_valid;
   logic [cache_lines-1:0] d_valid;
   logic [cache_lines-1:0] d_dirty;
   logic [cache_tag_bits-1:0] i_tag [cache_lines];
   logic [cache_tag_bits-1:0] d_tag [cache_lines];
   rv32i_word exp_ctr [num_event_counters];

   mem_heirarchy i_mem_heirarchy (.*);
   pmem_model pmem (.*);

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   function automatic rv32i_word shadow_read(rv32i_word a);
      rv32i_word w;
      w = {a[31:2], 2'b00};
      if (shadow.exists(w)) begin
         return shadow[w];
      end
      return w ^ 32'hA5A5A5A5;
   endfunction

   task automatic shadow_write(rv32i_word a, rv32i_word d, logic [3:0] m);
      rv32i_word v;
      v = shadow_read(a);
      for (int b = 0; b < 4; b++) begin
         if (m[b]) begin
            v[b*8 +: 8] = d[b*8 +: 8];
         end
      end
      shadow[{a[31:2], 2'b00}] = v;
   endtask

   // counter selects 0 and 1 are icache hits and misses
   function automatic logic icache_access(rv32i_word a);
      addr_line_t l;
      l = a;
      if (i_valid[l.index] && i_tag[l.index] == l.tag) begin
         exp_ctr[0] = exp_ctr[0] + 1;
         return 1'b1;
      end
      exp_ctr[1] = exp_ctr[1] + 1;
      i_valid[l.index] = 1'b1;
      i_tag[l.index] = l.tag;
      return 1'b0;
   endfunction

   // selects 2 and 3 are dcache hits and misses, 4 counts drained victims
   function automatic logic dcache_access(rv32i_word a, logic is_store);
      addr_line_t l;
      l = a;
      if (d_valid[l.index] && d_tag[l.index] == l.tag) begin
         exp_ctr[2] = exp_ctr[2] + 1;
         if (is_store) begin
            d_dirty[l.index] = 1'b1;
         end
         return 1'b1;
      end
      exp_ctr[3] = exp_ctr[3] + 1;
      if (d_valid[l.index] && d_dirty[l.index]) begin
         exp_ctr[4] = exp_ctr[4] + 1;
      end
      d_valid[l.index] = 1'b1;
      d_tag[l.index] = l.tag;
      d_dirty[l.index] = is_store;
      return 1'b0;
   endfunction

   function automatic rv32i_word ctr_addr(int sel);
      return {mmio_base, sel[5:0], 2'b00};
   endfunction

   function automatic rv32i_word counter_value(int sel);
      if (sel < num_event_counters) begin
         return exp_ctr[sel];
      end else if (sel == 5) begin
         return branch_total_count;
      end else if (sel == 6) begin
         return branch_incorrect_count;
      end
      return '0;
   endfunction

   task automatic add_row(string name, op_e op, rv32i_word a, rv32i_word d, logic [3:0] m);
      row_t r;
      addr_mmio_t w;
      w = a;
      r.port = (op == op_fetch) ? port_a : port_b;
      r.op = op;
      r.addr = a;
      r.wdata = d;
      r.wmask = m;
      r.expected = '0;
      r.fast = 1'b1;
      case (op)
         op_fetch: begin
            r.fast = icache_access(a);
            r.expected = shadow_read(a);
         end
         op_load: begin
            r.fast = dcache_access(a, 1'b0);
            r.expected = shadow_read(a);
         end
         op_store: begin
            r.fast = dcache_access(a, 1'b1);
            shadow_write(a, d, m);
         end
         op_ctr_read: r.expected = counter_value(int'(w.sel));
         default: begin
            if (w.sel < num_event_counters) begin
               exp_ctr[w.sel] = '0;
            end
         end
      endcase
      rows.push_back(r);
      names.push_back(name);
   endtask

   task automatic build_table();
      rv32i_word rnd;
      for (int i = 0; i < num_event_counters; i++) begin
         exp_ctr[i] = '0;
      end
      i_valid = '0;
      d_valid = '0;
      d_dirty = '0;

      // index 0 gets a conflicting line
      add_row("cold fetch", op_fetch, 32'h0000_0100, '0, '0);
      add_row("fetch same line", op_fetch, 32'h0000_0104, '0, '0);
      add_row("fetch line end", op_fetch, 32'h0000_011C, '0, '0);
      add_row("fetch conflict", op_fetch, 32'h0000_0200, '0, '0);
      add_row("fetch evicted", op_fetch, 32'h0000_0104, '0, '0);
      add_row("cold fetch idx 5", op_fetch, 32'h0000_03A8, '0, '0);

      add_row("store low bytes", op_store, 32'h0001_0040, 32'h1122_3344, 4'b0101);
      add_row("load merged", op_load, 32'h0001_0040, '0, '0);
      add_row("store full word", op_store, 32'h0001_0044, 32'h5566_7788, 4'b1111);
      add_row("store top byte", op_store, 32'h0001_0040, 32'h9900_0000, 4'b1000);
      add_row("load merged again", op_load, 32'h0001_0040, '0, '0);
      add_row("load next word", op_load, 32'h0001_0044, '0, '0);

      // dirty victim in index 3 leaves through the buffer
      add_row("store victim", op_store, 32'h0001_0060, 32'hCAFE_F00D, 4'b1111);
      add_row("load conflict", op_load, 32'h0002_0060, '0, '0);
      add_row("reload victim", op_load, 32'h0001_0060, '0, '0);
      add_row("store miss half", op_store, 32'h0003_0064, 32'h0000_BEEF, 4'b0011);
      add_row("reload after store miss", op_load, 32'h0001_0060, '0, '0);
      add_row("load store miss line", op_load, 32'h0003_0064, '0, '0);

      for (int s = 0; s < num_event_counters; s++) begin
         add_row("counter read", op_ctr_read, ctr_addr(s), '0, '0);
      end
      add_row("clear icache hits", op_ctr_write, ctr_addr(0), '0, 4'b1111);
      add_row("read cleared icache hits", op_ctr_read, ctr_addr(0), '0, '0);
      add_row("clear dcache misses", op_ctr_write, ctr_addr(3), '0, 4'b1111);
      add_row("read cleared dcache misses", op_ctr_read, ctr_addr(3), '0, '0);

      add_row("branch total", op_ctr_read, ctr_addr(5), '0, '0);
      add_row("branch incorrect", op_ctr_read, ctr_addr(6), '0, '0);
      add_row("reset branch total", op_ctr_write, ctr_addr(5), '0, 4'b1111);
      add_row("reset branch incorrect", op_ctr_write, ctr_addr(6), '0, 4'b1111);
      add_row("branch total again", op_ctr_read, ctr_addr(5), '0, '0);

      // fetch region stays apart from the store region
      for (int k = 0; k < random_rows; k++) begin
         rnd = $urandom();
         if (rnd[0]) begin
            add_row("random fetch", op_fetch, {21'b0, rnd[10:2], 2'b00}, '0, '0);
         end else begin
            add_row("random load", op_load, 32'h0001_0000 | {21'b0, rnd[20:12], 2'b00},
                    '0, '0);
         end
      end

      for (int s = 0; s < num_event_counters; s++) begin
         add_row("final counter read", op_ctr_read, ctr_addr(s), '0, '0);
      end
   endtask

   task automatic check(string name, rv32i_word exp, rv32i_word act);
      if (exp !== act) begin
         $display("Mismatch %s: expected %h, actual %h", name, exp, act);
         $display("Simulation FAILED");
         $fatal(1, "value check failed");
      end
   endtask

   task automatic idle_inputs();
      read_a = 1'b0;
      address_a = '0;
      read_b = 1'b0;
      write = 1'b0;
      wmask = '0;
      address_b = '0;
      wdata = '0;
   endtask

   task automatic apply_row(int n);
      row_t r;
      string label;
      addr_mmio_t w;
      int cycles;
      logic got;
      r = rows[n];
      label = $sformatf("row %0d %s", n, names[n]);
      w = r.addr;
      @(posedge clk);
      #drive_delay;
      read_a = (r.op == op_fetch);
      address_a = r.addr;
      read_b = (r.op == op_load) || (r.op == op_ctr_read);
      write = (r.op == op_store) || (r.op == op_ctr_write);
      address_b = r.addr;
      wdata = r.wdata;
      wmask = r.wmask;

      // the request is sampled at the next edge
      @(posedge clk);

      // outputs are sampled mid-cycle
      cycles = 0;
      got = 1'b0;
      while (!got) begin
         @(negedge clk);
         cycles++;
         got = (r.port == port_a) ? resp_a : resp_b;
      end

      if (r.fast) begin
         check({label, " latency"}, 32'd1, 32'(cycles));
      end
      case (r.op)
         op_fetch: check(label, r.expected, rdata_a);
         op_load, op_ctr_read: check(label, r.expected, rdata_b);
         default: ;
      endcase
      if (r.port == port_b) begin
         check({label, " total reset"},
               {31'b0, r.op == op_ctr_write && w.sel == 6'd5}, {31'b0, branch_total_reset});
         check({label, " incorrect reset"},
               {31'b0, r.op == op_ctr_write && w.sel == 6'd6},
               {31'b0, branch_incorrect_reset});
      end

      @(posedge clk);
      #drive_delay;
      idle_inputs();
   endtask

   initial begin
      table_ready = 1'b0;
      void'($urandom(47322));
      idle_inputs();
      rst_n = 1'b0;
      branch_total_count = $urandom();
      branch_incorrect_count = $urandom();
      build_table();
      table_ready = 1'b1;

      repeat (reset_cycles) @(posedge clk);
      #drive_delay;
      // resp, pmem strobes and branch resets are all low in reset
      check("reset outputs", '0,
            {26'b0, resp_a, resp_b, pmem_read, pmem_write,
             branch_total_reset, branch_incorrect_reset});
      rst_n = 1'b1;

      for (int n = 0; n < rows.size(); n++) begin
         apply_row(n);
      end
      $display("Simulation PASSED");
      $finish;
   end

   // watchdog
   initial begin
      wait (table_ready === 1'b1);
      repeat (reset_cycles + rows.size() * cycles_per_row) @(posedge clk);
      $display("timeout: the table did not finish within %0d cycles",
               reset_cycles + rows.size() * cycles_per_row);
      $display("Simulation FAILED");
      $fatal(1, "watchdog expired");
   end

endmodule : tb_mem_heirarchy
